// ==== rtl/decode_pkg.sv ====
package decode_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_W      = 5;
  localparam int TAG_W      = 4;
  localparam int NUM_FU     = 4;
  localparam int SLOT_IDX_W = $clog2(NUM_FU);
  localparam int LAT_W      = 5;

  // Cycles from acceptance to writeback
  localparam int LAT_ARITH    = 1;
  localparam int LAT_MUL      = 4;
  localparam int LAT_DIV      = 18;
  localparam int LAT_DIV_FAST = 1;
  localparam int WB_WINDOW    = 19;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [REG_W-1:0]  reg_idx_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [LAT_W-1:0]  lat_t;
  typedef logic [3:0]        op_t;

  // RV32 major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // Arith unit ops
  localparam op_t OP_ADD  = 4'd0;
  localparam op_t OP_SUB  = 4'd1;
  localparam op_t OP_AND  = 4'd2;
  localparam op_t OP_OR   = 4'd3;
  localparam op_t OP_XOR  = 4'd4;
  localparam op_t OP_SLL  = 4'd5;
  localparam op_t OP_SRL  = 4'd6;
  localparam op_t OP_SRA  = 4'd7;
  localparam op_t OP_SLT  = 4'd8;
  localparam op_t OP_SLTU = 4'd9;

  // Mul and div ops follow funct3[1:0]
  localparam op_t OP_MUL    = 4'd0;
  localparam op_t OP_MULH   = 4'd1;
  localparam op_t OP_MULHSU = 4'd2;
  localparam op_t OP_MULHU  = 4'd3;
  localparam op_t OP_DIV    = 4'd0;
  localparam op_t OP_DIVU   = 4'd1;
  localparam op_t OP_REM    = 4'd2;
  localparam op_t OP_REMU   = 4'd3;

  // Load/store ops
  localparam op_t OP_LOAD_W  = 4'd0;
  localparam op_t OP_STORE_W = 4'd1;

  typedef enum logic [1:0] {
    FU_ARITH = 2'd0,
    FU_MUL   = 2'd1,
    FU_DIV   = 2'd2,
    FU_LSU   = 2'd3
  } fu_t;

  typedef enum logic [1:0] {
    SRC_A_RS1  = 2'd0,
    SRC_A_PC   = 2'd1,
    SRC_A_ZERO = 2'd2
  } src_a_t;

  typedef enum logic [1:0] {
    SRC_B_RS2   = 2'd0,
    SRC_B_IMM_I = 2'd1,
    SRC_B_IMM_S = 2'd2,
    SRC_B_IMM_U = 2'd3
  } src_b_t;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } fetch_t;

  typedef struct packed {
    fu_t      fu;
    op_t      op;
    src_a_t   src_a;
    src_b_t   src_b;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     wen;
    word_t    imm_i;
    word_t    imm_s;
    word_t    imm_u;
  } ctrl_t;

  typedef struct packed {
    fu_t      fu;
    op_t      op;
    tag_t     tag;
    reg_idx_t rd;
    logic     wen;
    word_t    pc;
    word_t    port_a;
    word_t    port_b;
    word_t    store_data;
  } issue_t;

endpackage

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ns

module instr_decoder (
  input  decode_pkg::word_t instr,
  output decode_pkg::ctrl_t ctrl
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            is_shift;
  logic            wen_raw;
  decode_pkg::op_t arith_op;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

  // Bit 30 picks SUB and SRA over ADD and SRL
  always_comb begin
    case (funct3)
      3'b000: begin
        if (opcode == decode_pkg::OPC_OP && instr[30]) begin
          arith_op = decode_pkg::OP_SUB;
        end else begin
          arith_op = decode_pkg::OP_ADD;
        end
      end
      3'b001: arith_op = decode_pkg::OP_SLL;
      3'b010: arith_op = decode_pkg::OP_SLT;
      3'b011: arith_op = decode_pkg::OP_SLTU;
      3'b100: arith_op = decode_pkg::OP_XOR;
      3'b101: arith_op = instr[30] ? decode_pkg::OP_SRA : decode_pkg::OP_SRL;
      3'b110: arith_op = decode_pkg::OP_OR;
      default: arith_op = decode_pkg::OP_AND;
    endcase
  end

  always_comb begin
    ctrl       = '0;
    wen_raw    = 1'b0;
    ctrl.fu    = decode_pkg::FU_ARITH;
    ctrl.op    = decode_pkg::OP_ADD;
    ctrl.src_a = decode_pkg::SRC_A_ZERO;
    ctrl.src_b = decode_pkg::SRC_B_IMM_I;
    ctrl.rs1   = instr[19:15];
    ctrl.rs2   = instr[24:20];
    ctrl.imm_i = {{20{instr[31]}}, instr[31:20]};
    ctrl.imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    ctrl.imm_u = {instr[31:12], 12'b0};

    case (opcode)
      decode_pkg::OPC_OP: begin
        ctrl.src_a = decode_pkg::SRC_A_RS1;
        ctrl.src_b = decode_pkg::SRC_B_RS2;
        wen_raw    = 1'b1;
        // M extension ops come from the funct3 low bits
        if (funct7 == 7'b0000001) begin
          ctrl.fu = funct3[2] ? decode_pkg::FU_DIV : decode_pkg::FU_MUL;
          ctrl.op = decode_pkg::op_t'(funct3[1:0]);
        end else begin
          ctrl.op = arith_op;
        end
      end
      decode_pkg::OPC_OP_IMM: begin
        ctrl.op    = arith_op;
        ctrl.src_a = decode_pkg::SRC_A_RS1;
        wen_raw    = 1'b1;
        if (is_shift) begin
          ctrl.imm_i = {27'b0, instr[24:20]};
        end
      end
      decode_pkg::OPC_LUI: begin
        ctrl.src_b = decode_pkg::SRC_B_IMM_U;
        wen_raw    = 1'b1;
      end
      decode_pkg::OPC_AUIPC: begin
        ctrl.src_a = decode_pkg::SRC_A_PC;
        ctrl.src_b = decode_pkg::SRC_B_IMM_U;
        wen_raw    = 1'b1;
      end
      decode_pkg::OPC_LOAD: begin
        ctrl.fu    = decode_pkg::FU_LSU;
        ctrl.op    = decode_pkg::OP_LOAD_W;
        ctrl.src_a = decode_pkg::SRC_A_RS1;
        wen_raw    = 1'b1;
      end
      decode_pkg::OPC_STORE: begin
        ctrl.fu    = decode_pkg::FU_LSU;
        ctrl.op    = decode_pkg::OP_STORE_W;
        ctrl.src_a = decode_pkg::SRC_A_RS1;
        ctrl.src_b = decode_pkg::SRC_B_IMM_S;
      end
      default: begin
        // Unknown opcode issues as 0 + 0 with no write
        ctrl.imm_i = '0;
      end
    endcase

    // Writes to x0 are dropped
    ctrl.wen = wen_raw && (instr[11:7] != '0);
    ctrl.rd  = ctrl.wen ? instr[11:7] : '0;
  end

endmodule

// ==== rtl/dispatch_front.sv ====
`timescale 1ns/1ns

module dispatch_front (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          fetch_valid,
  input  decode_pkg::fetch_t            fetch,
  input  decode_pkg::word_t             rs1_data,
  input  decode_pkg::word_t             rs2_data,
  input  logic [decode_pkg::NUM_FU-1:0] slot_full,
  input  logic                          wb_conflict,
  output logic                          fetch_ready,
  output decode_pkg::reg_idx_t          rs1_addr,
  output decode_pkg::reg_idx_t          rs2_addr,
  output logic [decode_pkg::NUM_FU-1:0] load,
  output decode_pkg::issue_t            entry,
  output logic                          wb_req,
  output decode_pkg::lat_t              wb_lat
);

  decode_pkg::ctrl_t ctrl;
  decode_pkg::word_t port_a;
  decode_pkg::word_t port_b;
  decode_pkg::tag_t  tag_q;
  logic              div_fast;
  logic              accept;

  instr_decoder u_instr_decoder (
    .instr (fetch.instr),
    .ctrl  (ctrl)
  );

  assign rs1_addr = ctrl.rs1;
  assign rs2_addr = ctrl.rs2;

  always_comb begin
    case (ctrl.src_a)
      decode_pkg::SRC_A_RS1: port_a = rs1_data;
      decode_pkg::SRC_A_PC:  port_a = fetch.pc;
      default:               port_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.src_b)
      decode_pkg::SRC_B_RS2:   port_b = rs2_data;
      decode_pkg::SRC_B_IMM_I: port_b = ctrl.imm_i;
      decode_pkg::SRC_B_IMM_S: port_b = ctrl.imm_s;
      default:                 port_b = ctrl.imm_u;
    endcase
  end

  // Divide by zero, by -1 or of the most negative value finishes early
  assign div_fast = (port_b == '0) || (port_b == '1) || (port_a == 32'h8000_0000);

  always_comb begin
    case (ctrl.fu)
      decode_pkg::FU_ARITH: wb_lat = decode_pkg::lat_t'(decode_pkg::LAT_ARITH);
      decode_pkg::FU_MUL:   wb_lat = decode_pkg::lat_t'(decode_pkg::LAT_MUL);
      decode_pkg::FU_DIV: begin
        wb_lat = div_fast ? decode_pkg::lat_t'(decode_pkg::LAT_DIV_FAST)
                          : decode_pkg::lat_t'(decode_pkg::LAT_DIV);
      end
      default:              wb_lat = '0;
    endcase
  end

  // Load/store results do not use the shared writeback port
  assign wb_req      = ctrl.wen && (ctrl.fu != decode_pkg::FU_LSU);
  assign fetch_ready = !slot_full[ctrl.fu] && !wb_conflict;
  assign accept      = fetch_valid && fetch_ready;
  assign load        = accept ? ({{(decode_pkg::NUM_FU-1){1'b0}}, 1'b1} << ctrl.fu) : '0;

  // Completion buffer tail
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      tag_q <= '0;
    end else if (accept) begin
      tag_q <= tag_q + 1'b1;
    end
  end

  always_comb begin
    entry        = '0;
    entry.fu     = ctrl.fu;
    entry.op     = ctrl.op;
    entry.tag    = tag_q;
    entry.rd     = ctrl.rd;
    entry.wen    = ctrl.wen;
    entry.pc     = fetch.pc;
    entry.port_a = port_a;
    entry.port_b = port_b;
    if (ctrl.fu == decode_pkg::FU_LSU && ctrl.op == decode_pkg::OP_STORE_W) begin
      entry.store_data = rs2_data;
    end
  end

endmodule

// ==== rtl/wb_slot_tracker.sv ====
`timescale 1ns/1ns

module wb_slot_tracker (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             wb_req,
  input  decode_pkg::lat_t wb_lat,
  input  logic             accept,
  output logic             conflict
);

  // Bit k marks the writeback port as taken k+1 cycles from now
  logic [decode_pkg::WB_WINDOW-1:0] resv_q;
  logic [decode_pkg::WB_WINDOW-1:0] resv_next;
  logic [decode_pkg::WB_WINDOW-1:0] lat_mask;

  // One-hot for the requested writeback cycle
  always_comb begin
    lat_mask = '0;
    if (wb_req) begin
      lat_mask = {{(decode_pkg::WB_WINDOW-1){1'b0}}, 1'b1} << (wb_lat - 1'b1);
    end
  end

  assign conflict = |(resv_q & lat_mask);

  always_comb begin
    resv_next = resv_q;
    if (accept) begin
      resv_next = resv_q | lat_mask;
    end
  end

  // Shifts every cycle whether or not anything was accepted
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      resv_q <= '0;
    end else begin
      resv_q <= resv_next >> 1;
    end
  end

endmodule

// ==== rtl/issue_slot.sv ====
`timescale 1ns/1ns

module issue_slot (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               load,
  input  decode_pkg::issue_t entry,
  input  logic               take,
  output logic               full,
  output decode_pkg::issue_t held
);

  // Occupancy flag
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (take) begin
      full <= 1'b0;
    end
  end

  // Payload only changes on load
  always_ff @(posedge CLK) begin
    if (load) begin
      held <= entry;
    end
  end

endmodule

// ==== rtl/issue_arbiter.sv ====
`timescale 1ns/1ns

module issue_arbiter (
  input  logic [decode_pkg::NUM_FU-1:0]                     full,
  input  decode_pkg::issue_t [decode_pkg::NUM_FU-1:0]       held,
  input  logic                                              issue_ready,
  output logic [decode_pkg::NUM_FU-1:0]                     take,
  output logic                                              issue_valid,
  output decode_pkg::issue_t                                issue
);

  logic [decode_pkg::SLOT_IDX_W-1:0] sel;

  // Lowest numbered full slot wins
  always_comb begin
    sel = '0;
    for (int i = decode_pkg::NUM_FU - 1; i >= 0; i--) begin
      if (full[i]) begin
        sel = decode_pkg::SLOT_IDX_W'(i);
      end
    end
  end

  assign issue_valid = |full;
  assign issue       = held[sel];

  // Slot is released only on the execute handshake
  always_comb begin
    take      = '0;
    take[sel] = issue_valid && issue_ready;
  end

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 fetch_valid,
  output logic                 fetch_ready,
  input  decode_pkg::fetch_t   fetch,
  output decode_pkg::reg_idx_t rs1_addr,
  output decode_pkg::reg_idx_t rs2_addr,
  input  decode_pkg::word_t    rs1_data,
  input  decode_pkg::word_t    rs2_data,
  output logic                 issue_valid,
  input  logic                 issue_ready,
  output decode_pkg::issue_t   issue
);

  logic [decode_pkg::NUM_FU-1:0]               slot_full;
  logic [decode_pkg::NUM_FU-1:0]               slot_load;
  logic [decode_pkg::NUM_FU-1:0]               slot_take;
  decode_pkg::issue_t [decode_pkg::NUM_FU-1:0] slot_held;
  decode_pkg::issue_t                          entry;
  logic                                        wb_req;
  decode_pkg::lat_t                            wb_lat;
  logic                                        wb_conflict;

  dispatch_front u_dispatch_front (
    .CLK         (CLK),
    .nRST        (nRST),
    .fetch_valid (fetch_valid),
    .fetch       (fetch),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .slot_full   (slot_full),
    .wb_conflict (wb_conflict),
    .fetch_ready (fetch_ready),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .load        (slot_load),
    .entry       (entry),
    .wb_req      (wb_req),
    .wb_lat      (wb_lat)
  );

  // Reservation is committed on the fetch handshake
  wb_slot_tracker u_wb_slot_tracker (
    .CLK      (CLK),
    .nRST     (nRST),
    .wb_req   (wb_req),
    .wb_lat   (wb_lat),
    .accept   (fetch_valid & fetch_ready),
    .conflict (wb_conflict)
  );

  // One slot per functional unit, indexed by fu_t
  for (genvar i = 0; i < decode_pkg::NUM_FU; i++) begin : g_slot
    issue_slot u_issue_slot (
      .CLK   (CLK),
      .nRST  (nRST),
      .load  (slot_load[i]),
      .entry (entry),
      .take  (slot_take[i]),
      .full  (slot_full[i]),
      .held  (slot_held[i])
    );
  end

  issue_arbiter u_issue_arbiter (
    .full        (slot_full),
    .held        (slot_held),
    .issue_ready (issue_ready),
    .take        (slot_take),
    .issue_valid (issue_valid),
    .issue       (issue)
  );

endmodule

// ==== bench/decode_stage_checker.sv ====
`timescale 1ns/1ns

module decode_stage_checker (
  input logic                          CLK,
  input logic                          nRST,
  input logic                          fetch_valid,
  input logic                          fetch_ready,
  input decode_pkg::fetch_t            fetch,
  input logic                          issue_valid,
  input logic                          issue_ready,
  input decode_pkg::issue_t            issue,
  input logic [decode_pkg::NUM_FU-1:0] slot_load
);

  // Fetch source holds its payload until accepted
  a_fetch_hold: assert property (@(posedge CLK) disable iff (!nRST)
    fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch))
    else $error("fetch payload changed while stalled");

  a_issue_valid_hold: assert property (@(posedge CLK) disable iff (!nRST)
    issue_valid && !issue_ready |=> issue_valid)
    else $error("issue_valid dropped before the handshake");

  // A lower slot loading under back-pressure moves the bus to that slot
  a_issue_hold: assert property (@(posedge CLK) disable iff (!nRST)
    issue_valid && !issue_ready && (slot_load == '0) |=> $stable(issue))
    else $error("issue payload changed while stalled");

  a_issue_known: assert property (@(posedge CLK) disable iff (!nRST)
    !$isunknown(issue_valid))
    else $error("issue_valid is unknown");

endmodule

// ==== bench/decode_stage_tb.sv ====
`timescale 1ns/1ns

module decode_stage_tb;

  localparam int NUM_INSTR = 300;
  localparam int TIMEOUT   = NUM_INSTR * 24 + 200;

  logic                 CLK;
  logic                 nRST;
  logic                 fetch_valid;
  logic                 fetch_ready;
  decode_pkg::fetch_t   fetch;
  decode_pkg::reg_idx_t rs1_addr;
  decode_pkg::reg_idx_t rs2_addr;
  decode_pkg::word_t    rs1_data;
  decode_pkg::word_t    rs2_data;
  logic                 issue_valid;
  logic                 issue_ready;
  decode_pkg::issue_t   issue;

  logic [15:0]                   lfsr = 16'd44040;
  int                            cycle = 0;
  int                            accepted = 0;
  int                            issued = 0;
  int                            errors = 0;
  logic [decode_pkg::NUM_FU-1:0] occupied = '0;
  decode_pkg::tag_t              slot_tag [decode_pkg::NUM_FU];
  decode_pkg::issue_t            exp_q [16];
  bit                            reserved [int];

  decode_stage u_decode_stage (
    .CLK         (CLK),
    .nRST        (nRST),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .fetch       (fetch),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue       (issue)
  );

  bind decode_stage decode_stage_checker u_decode_stage_checker (
    .CLK         (CLK),
    .nRST        (nRST),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .fetch       (fetch),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue       (issue),
    .slot_load   (slot_load)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Register model where x1 and x2 give the fast divide operands
  function automatic decode_pkg::word_t reg_val(input decode_pkg::reg_idx_t i);
    case (i)
      5'd0: return '0;
      5'd1: return '1;
      5'd2: return 32'h8000_0000;
      default: return (32'(i) * 32'h0101_0101) ^ 32'h5a5a_5a5a;
    endcase
  endfunction

  assign rs1_data = reg_val(rs1_addr);
  assign rs2_data = reg_val(rs2_addr);

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Low registers half the time
  function automatic decode_pkg::reg_idx_t pick_reg();
    if (rand_bits(1) == 32'd1) begin
      return 5'(rand_bits(2));
    end
    return 5'(rand_bits(5));
  endfunction

  function automatic decode_pkg::word_t make_instr();
    logic [3:0]        kind;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [11:0]       imm;
    logic [19:0]       uimm;
    decode_pkg::word_t w;
    kind = 4'(rand_bits(4) % 13);
    rd   = 5'(rand_bits(5));
    rs1  = pick_reg();
    rs2  = pick_reg();
    imm  = 12'(rand_bits(12));
    uimm = 20'(rand_bits(20));
    case (kind)
      4'd0:  w = {imm, rs1, 3'b000, rd, decode_pkg::OPC_OP_IMM};
      4'd1:  w = {7'b0000000, rs2, rs1, 3'b000, rd, decode_pkg::OPC_OP};
      4'd2:  w = {7'b0100000, rs2, rs1, 3'b000, rd, decode_pkg::OPC_OP};
      // SRAI with the shamt in the rs2 field
      4'd3:  w = {7'b0100000, rs2, rs1, 3'b101, rd, decode_pkg::OPC_OP_IMM};
      4'd4:  w = {7'b0000000, rs2, rs1, 3'b011, rd, decode_pkg::OPC_OP};
      4'd5:  w = {uimm, rd, decode_pkg::OPC_LUI};
      4'd6:  w = {uimm, rd, decode_pkg::OPC_AUIPC};
      4'd7:  w = {7'b0000001, rs2, rs1, 3'b000, rd, decode_pkg::OPC_OP};
      4'd8:  w = {7'b0000001, rs2, rs1, 3'b011, rd, decode_pkg::OPC_OP};
      4'd9:  w = {7'b0000001, rs2, rs1, 3'b100, rd, decode_pkg::OPC_OP};
      4'd10: w = {7'b0000001, rs2, rs1, 3'b111, rd, decode_pkg::OPC_OP};
      4'd11: w = {imm, rs1, 3'b010, rd, decode_pkg::OPC_LOAD};
      default: w = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], decode_pkg::OPC_STORE};
    endcase
    return w;
  endfunction

  function automatic decode_pkg::op_t alu_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000: return alt ? decode_pkg::OP_SUB : decode_pkg::OP_ADD;
      3'b001: return decode_pkg::OP_SLL;
      3'b010: return decode_pkg::OP_SLT;
      3'b011: return decode_pkg::OP_SLTU;
      3'b100: return decode_pkg::OP_XOR;
      3'b101: return alt ? decode_pkg::OP_SRA : decode_pkg::OP_SRL;
      3'b110: return decode_pkg::OP_OR;
      default: return decode_pkg::OP_AND;
    endcase
  endfunction

  function automatic decode_pkg::op_t muldiv_op(input logic [2:0] f3);
    case (f3)
      3'd0: return decode_pkg::OP_MUL;
      3'd1: return decode_pkg::OP_MULH;
      3'd2: return decode_pkg::OP_MULHSU;
      3'd3: return decode_pkg::OP_MULHU;
      3'd4: return decode_pkg::OP_DIV;
      3'd5: return decode_pkg::OP_DIVU;
      3'd6: return decode_pkg::OP_REM;
      default: return decode_pkg::OP_REMU;
    endcase
  endfunction

  // Expected execute payload for one fetched instruction
  function automatic decode_pkg::issue_t ref_issue(input decode_pkg::word_t pc,
                                                   input decode_pkg::word_t instr,
                                                   input decode_pkg::tag_t tag);
    decode_pkg::issue_t e;
    logic [2:0]         f3;
    decode_pkg::word_t  imm_i;
    decode_pkg::word_t  imm_u;
    f3    = instr[14:12];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_u = {instr[31:12], 12'h000};
    e     = '0;
    e.fu  = decode_pkg::FU_ARITH;
    e.op  = decode_pkg::OP_ADD;
    e.tag = tag;
    e.pc  = pc;
    case (instr[6:0])
      decode_pkg::OPC_OP: begin
        e.port_a = reg_val(instr[19:15]);
        e.port_b = reg_val(instr[24:20]);
        e.wen    = 1'b1;
        if (instr[31:25] == 7'b0000001) begin
          e.fu = (f3 < 3'd4) ? decode_pkg::FU_MUL : decode_pkg::FU_DIV;
          e.op = muldiv_op(f3);
        end else begin
          e.op = alu_op(f3, instr[30]);
        end
      end
      decode_pkg::OPC_OP_IMM: begin
        e.op     = alu_op(f3, (f3 == 3'b101) && instr[30]);
        e.port_a = reg_val(instr[19:15]);
        e.port_b = (f3 == 3'b001 || f3 == 3'b101) ? {27'b0, instr[24:20]} : imm_i;
        e.wen    = 1'b1;
      end
      decode_pkg::OPC_LUI: begin
        e.port_b = imm_u;
        e.wen    = 1'b1;
      end
      decode_pkg::OPC_AUIPC: begin
        e.port_a = pc;
        e.port_b = imm_u;
        e.wen    = 1'b1;
      end
      decode_pkg::OPC_LOAD: begin
        e.fu     = decode_pkg::FU_LSU;
        e.op     = decode_pkg::OP_LOAD_W;
        e.port_a = reg_val(instr[19:15]);
        e.port_b = imm_i;
        e.wen    = 1'b1;
      end
      decode_pkg::OPC_STORE: begin
        e.fu         = decode_pkg::FU_LSU;
        e.op         = decode_pkg::OP_STORE_W;
        e.port_a     = reg_val(instr[19:15]);
        e.port_b     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        e.store_data = reg_val(instr[24:20]);
      end
      default: e.wen = 1'b0;
    endcase
    if (instr[11:7] == 5'd0) begin
      e.wen = 1'b0;
    end
    e.rd = e.wen ? instr[11:7] : 5'd0;
    return e;
  endfunction

  function automatic int lat_of(input decode_pkg::issue_t e);
    case (e.fu)
      decode_pkg::FU_MUL: return decode_pkg::LAT_MUL;
      decode_pkg::FU_DIV: begin
        if (e.port_b == '0 || e.port_b == '1 || e.port_a == 32'h8000_0000) begin
          return decode_pkg::LAT_DIV_FAST;
        end
        return decode_pkg::LAT_DIV;
      end
      default: return decode_pkg::LAT_ARITH;
    endcase
  endfunction

  task automatic fail_run(input string why);
    errors++;
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  always @(posedge CLK) begin
    cycle <= cycle + 1;
    if (cycle > TIMEOUT) begin
      fail_run($sformatf("timeout: run still busy after %0d cycles", cycle));
    end
  end

  // Sampled at the edge before the DUT registers update
  always @(posedge CLK) begin : compare
    decode_pkg::issue_t            exp_e;
    decode_pkg::issue_t            exp_t;
    logic [decode_pkg::NUM_FU-1:0] occ_pre;
    logic                          wb;
    int                            lat;
    int                            s;
    occ_pre = occupied;
    if (cycle != 0) begin
      check("issue_valid", 32'(issue_valid), 32'(|occ_pre));
    end
    if (nRST && fetch_valid) begin
      check("rs1_addr", 32'(rs1_addr), 32'(fetch.instr[19:15]));
      check("rs2_addr", 32'(rs2_addr), 32'(fetch.instr[24:20]));
      exp_e = ref_issue(fetch.pc, fetch.instr, decode_pkg::tag_t'(accepted));
      wb    = exp_e.wen && (exp_e.fu != decode_pkg::FU_LSU);
      lat   = lat_of(exp_e);
      check("fetch_ready", 32'(fetch_ready),
            32'(!occ_pre[exp_e.fu] && !(wb && reserved.exists(cycle + lat))));
      if (fetch_ready) begin
        if (wb) begin
          reserved[cycle + lat] = 1'b1;
        end
        exp_q[exp_e.tag]   = exp_e;
        slot_tag[exp_e.fu] = exp_e.tag;
        occupied[exp_e.fu] = 1'b1;
        accepted++;
      end
    end
    if (nRST && issue_valid && issue_ready) begin
      s = 0;
      for (int i = decode_pkg::NUM_FU - 1; i >= 0; i--) begin
        if (occ_pre[i]) s = i;
      end
      exp_t = exp_q[slot_tag[s]];
      check("issue.tag", 32'(issue.tag), 32'(exp_t.tag));
      check("issue.fu", 32'(issue.fu), 32'(exp_t.fu));
      check("issue.op", 32'(issue.op), 32'(exp_t.op));
      check("issue.rd", 32'(issue.rd), 32'(exp_t.rd));
      check("issue.wen", 32'(issue.wen), 32'(exp_t.wen));
      check("issue.pc", issue.pc, exp_t.pc);
      check("issue.port_a", issue.port_a, exp_t.port_a);
      check("issue.port_b", issue.port_b, exp_t.port_b);
      check("issue.store_data", issue.store_data, exp_t.store_data);
      occupied[s] = 1'b0;
      issued++;
    end
  end

  initial begin : stimulus
    int                sent;
    int                stall;
    decode_pkg::word_t pc;
    sent        = 0;
    stall       = 0;
    pc          = 32'h0000_1000;
    nRST        = 1'b0;
    fetch_valid = 1'b0;
    fetch       = '0;
    issue_ready = 1'b0;
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    while (sent < NUM_INSTR) begin
      @(posedge CLK);
      if (fetch_valid && fetch_ready) sent++;
      if (!fetch_valid || fetch_ready) begin
        if (sent < NUM_INSTR && rand_bits(2) != 32'd0) begin
          fetch_valid <= 1'b1;
          fetch       <= {pc, make_instr()};
          pc           = pc + 32'd4;
        end else begin
          fetch_valid <= 1'b0;
        end
      end
      // Occasional long stretches of execute back-pressure
      if (stall > 0) begin
        stall--;
        issue_ready <= 1'b0;
      end else if (rand_bits(4) == 32'd0) begin
        stall = int'(rand_bits(5));
        issue_ready <= 1'b0;
      end else begin
        issue_ready <= 1'b1;
      end
    end
    issue_ready <= 1'b1;
    // Drain until the DUT has no slot left to issue
    @(posedge CLK);
    while (issue_valid) @(posedge CLK);
    check("issued count", 32'(issued), 32'(accepted));
    if (errors == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("*** FAILED ***");
      $fatal(1);
    end
  end

endmodule

// ==== files.f ====
rtl/decode_pkg.sv
rtl/instr_decoder.sv
rtl/dispatch_front.sv
rtl/wb_slot_tracker.sv
rtl/issue_slot.sv
rtl/issue_arbiter.sv
rtl/decode_stage.sv
bench/decode_stage_checker.sv
bench/decode_stage_tb.sv

// ==== Makefile ====
TOP := decode_stage_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f files.f -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -F -q '*** PASSED ***' sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir sim.log
